// File: hdl/sdramCmdIf.sv
`timescale 1ns/100ps
`default_nettype none

interface sdramCmdIf
    import sdramPkg::*;
();

    sdramCmd_t            cmd;
    logic [ROW_BITS-1:0]  pinAddr;
    logic [BANK_BITS-1:0] bank;
    logic [1:0]           dqm;
    logic [15:0]          wrData;
    logic                 wrStrobe;    // WRITE this cycle, drive DQ on the pin cycle
    logic                 rdStrobe;    // READ this cycle, start the capture pipe
    logic [15:0]          rdData;
    logic                 rdDataValid;

    modport controller (
        output cmd, pinAddr, bank, dqm, wrData, wrStrobe, rdStrobe,
        input  rdData, rdDataValid
    );

    modport phy (
        input  cmd, pinAddr, bank, dqm, wrData, wrStrobe, rdStrobe,
        output rdData, rdDataValid
    );

endinterface

`default_nettype wire

// File: hdl/sdramController.sv
`timescale 1ns/100ps
`default_nettype none

module sdramController
    import sdramPkg::*;
#(
    parameter int initCycles      = 10000,
    parameter int refreshInterval = 780,
    parameter int tRcd            = 2,
    parameter int tRp             = 2,
    parameter int tRfc            = 7
) (
    input  logic              clk,
    input  logic              reset,
    sdramHostIf.controller    host,
    sdramCmdIf.controller     cmdOut,
    output logic              cke
);

    localparam int AP_BIT    = 10;   // auto-precharge select on READ/WRITE
    localparam int WAIT_A    = (initCycles > tRfc) ? initCycles : tRfc;
    localparam int WAIT_B    = (tRcd > tRp) ? tRcd : tRp;
    localparam int WAIT_MAX  = (WAIT_A > WAIT_B) ? WAIT_A : WAIT_B;
    localparam int WAIT_BITS = $clog2(WAIT_MAX + 1);
    localparam int REF_BITS  = $clog2(refreshInterval + 1);

    ctrlState_t           state;
    sdramCmd_t            cmdReg;
    logic [WAIT_BITS-1:0] waitCnt;
    logic [REF_BITS-1:0]  refCnt;     // reaches zero when a refresh is due
    logic                 initRefDone;
    logic                 accept;

    logic                 reqWrite;
    logic [BANK_BITS-1:0] reqBank;
    logic [ROW_BITS-1:0]  reqRow;
    logic [COL_BITS-1:0]  reqCol;
    logic [15:0]          reqData;
    logic [1:0]           reqDqm;

    // refresh wins over a waiting request
    assign accept           = (state == IDLE) && (refCnt != '0) && (host.rd || host.wr);
    assign host.waitRequest = !((state == IDLE) && (refCnt != '0));

    assign host.rdValid = cmdOut.rdDataValid;
    assign host.rdData  = cmdOut.rdData;

    assign cmdOut.cmd      = cmdReg;
    assign cmdOut.wrStrobe = (cmdReg == CMD_WRITE);
    assign cmdOut.rdStrobe = (cmdReg == CMD_READ);
    assign cmdOut.wrData   = reqData;
    assign cmdOut.dqm      = reqWrite ? reqDqm : 2'b00;

    always_comb begin
        cmdOut.pinAddr = reqRow;
        cmdOut.bank    = reqBank;
        case (state)
            INIT_WAIT, INIT_PRE, INIT_REF: begin
                cmdOut.pinAddr         = '0;
                cmdOut.pinAddr[AP_BIT] = 1'b1;   // precharge all banks
                cmdOut.bank            = '0;
            end
            INIT_MODE: begin
                cmdOut.pinAddr = MODE_WORD;
                cmdOut.bank    = '0;
            end
            ACCESS: begin
                cmdOut.pinAddr                 = '0;
                cmdOut.pinAddr[AP_BIT]         = 1'b1;
                cmdOut.pinAddr[COL_BITS-1:0]   = reqCol;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= INIT_WAIT;
            cmdReg      <= CMD_NOP;
            waitCnt     <= WAIT_BITS'(initCycles - 1);
            refCnt      <= REF_BITS'(refreshInterval - 1);
            initRefDone <= 1'b0;
            cke         <= 1'b0;
        end else begin
            cmdReg <= CMD_NOP;
            if (refCnt != '0) begin
                refCnt <= refCnt - 1'b1;
            end
            if (waitCnt != '0) begin
                waitCnt <= waitCnt - 1'b1;
            end
            case (state)
                INIT_WAIT: if (waitCnt == '0) begin
                    state   <= INIT_PRE;
                    cmdReg  <= CMD_PRECHARGE;
                    cke     <= 1'b1;
                    waitCnt <= WAIT_BITS'(tRp);
                end
                INIT_PRE: if (waitCnt == '0) begin
                    state   <= INIT_REF;
                    cmdReg  <= CMD_REFRESH;
                    waitCnt <= WAIT_BITS'(tRfc);
                end
                INIT_REF: if (waitCnt == '0) begin
                    if (!initRefDone) begin
                        cmdReg      <= CMD_REFRESH;   // second init refresh
                        waitCnt     <= WAIT_BITS'(tRfc);
                        initRefDone <= 1'b1;
                    end else begin
                        state   <= INIT_MODE;
                        cmdReg  <= CMD_LOADMODE;
                        waitCnt <= WAIT_BITS'(1);     // tMRD of two cycles
                    end
                end
                INIT_MODE: if (waitCnt == '0) begin
                    state  <= IDLE;
                    refCnt <= REF_BITS'(refreshInterval - 1);
                end
                IDLE: begin
                    if (refCnt == '0) begin
                        state   <= REFRESH_WAIT;
                        cmdReg  <= CMD_REFRESH;
                        waitCnt <= WAIT_BITS'(tRfc);
                        refCnt  <= REF_BITS'(refreshInterval - 1);
                    end else if (accept) begin
                        state  <= ACTIVATE;
                        cmdReg <= CMD_ACTIVE;
                    end
                end
                ACTIVATE: begin
                    state   <= RCD_WAIT;
                    waitCnt <= WAIT_BITS'(tRcd - 1);
                end
                RCD_WAIT: if (waitCnt == '0) begin
                    state  <= ACCESS;
                    cmdReg <= reqWrite ? CMD_WRITE : CMD_READ;
                end
                ACCESS: begin
                    state   <= RP_WAIT;
                    waitCnt <= WAIT_BITS'(tRp - 1);  // auto-precharge in progress
                end
                RP_WAIT, REFRESH_WAIT: if (waitCnt == '0) begin
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request payload taken on the accept edge
    always_ff @(posedge clk) begin
        if (accept) begin
            reqWrite <= host.wr;
            reqBank  <= host.addr[COL_BITS+ROW_BITS +: BANK_BITS];
            reqRow   <= host.addr[COL_BITS +: ROW_BITS];
            reqCol   <= host.addr[0 +: COL_BITS];
            reqData  <= host.wrData;
            reqDqm   <= host.byteEnableN;
        end
    end

    // the whole ACTIVE..precharge window stalls the next half
    accessStall: assert property (@(posedge clk) disable iff (reset)
        accept |=> host.waitRequest [* (tRcd + tRp + 2)])
        else $error("waitRequest dropped inside an access window");

    // second init refresh is the only command without a state change
    cmdAtEntry: assert property (@(posedge clk) disable iff (reset)
        cmdReg != CMD_NOP |-> (state != $past(state)) || $rose(initRefDone))
        else $error("command issued without a state entry, state %s", state.name());

endmodule

`default_nettype wire

// File: hdl/sdramHostIf.sv
`timescale 1ns/100ps
`default_nettype none

interface sdramHostIf
    import sdramPkg::*;
();

    logic [HOST_ADDR_BITS:0] addr;        // 16-bit word address, bank/row/col
    logic [1:0]              byteEnableN;
    logic [15:0]             wrData;
    logic                    rd;
    logic                    wr;
    logic                    waitRequest;
    logic                    rdValid;     // one pulse per returned 16-bit word
    logic [15:0]             rdData;

    modport adapter (
        output addr, byteEnableN, wrData, rd, wr,
        input  waitRequest, rdValid, rdData
    );

    modport controller (
        input  addr, byteEnableN, wrData, rd, wr,
        output waitRequest, rdValid, rdData
    );

endinterface

`default_nettype wire

// File: hdl/sdramPhy.sv
`timescale 1ns/100ps
`default_nettype none

module sdramPhy
    import sdramPkg::*;
#(
    parameter int casLatency = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    sdramCmdIf.phy               cmdIn,
    output logic [ROW_BITS-1:0]  sdramAddr,
    output logic [BANK_BITS-1:0] sdramBa,
    output logic [1:0]           sdramDqm,
    output logic                 sdramCasN,
    output logic                 sdramRasN,
    output logic                 sdramWeN,
    output logic                 sdramCsN,
    output logic [15:0]          dqOut,
    output logic                 dqOutEnable,
    input  logic [15:0]          dqIn
);

    logic [casLatency:0] rdShift;    // stage 0 lines up with READ on the pins
    logic [15:0]         rdCapture;

    assign cmdIn.rdData = rdCapture;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {sdramCsN, sdramRasN, sdramCasN, sdramWeN} <= CMD_NOP;
            dqOutEnable       <= 1'b0;
            rdShift           <= '0;
            cmdIn.rdDataValid <= 1'b0;
        end else begin
            {sdramCsN, sdramRasN, sdramCasN, sdramWeN} <= cmdIn.cmd;
            dqOutEnable       <= cmdIn.wrStrobe;   // same pin cycle as WRITE
            rdShift           <= {rdShift[casLatency-1:0], cmdIn.rdStrobe};
            cmdIn.rdDataValid <= rdShift[casLatency];
        end
    end

    always_ff @(posedge clk) begin
        sdramAddr <= cmdIn.pinAddr;
        sdramBa   <= cmdIn.bank;
        sdramDqm  <= cmdIn.dqm;
        dqOut     <= cmdIn.wrData;
        if (rdShift[casLatency]) begin
            rdCapture <= dqIn;   // data valid on DQ after CAS latency
        end
    end

    readReturn: assert property (@(posedge clk) disable iff (reset)
        {sdramCsN, sdramRasN, sdramCasN, sdramWeN} == CMD_READ
            |-> ##(casLatency + 1) cmdIn.rdDataValid)
        else $error("read data not returned at CAS latency + 1");

endmodule

`default_nettype wire

// File: hdl/sdramPkg.sv
`default_nettype none

package sdramPkg;

    // geometry of the 16-bit part
    localparam int ROW_BITS       = 13;
    localparam int COL_BITS       = 10;
    localparam int BANK_BITS      = 2;
    localparam int HOST_ADDR_BITS = 24;   // 32-bit word address on the host side

    // pin command encoding {csN, rasN, casN, weN}
    typedef enum logic [3:0] {
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001,
        CMD_LOADMODE  = 4'b0000
    } sdramCmd_t;

    // burst length 1, sequential, CAS latency 2, single-location write
    localparam logic [ROW_BITS-1:0] MODE_WORD = 13'h0220;

    typedef enum logic [3:0] {
        INIT_WAIT,
        INIT_PRE,
        INIT_REF,
        INIT_MODE,
        IDLE,
        ACTIVATE,
        RCD_WAIT,
        ACCESS,
        RP_WAIT,
        REFRESH_WAIT
    } ctrlState_t;

endpackage

`default_nettype wire

// File: hdl/sdramSubsystem.sv
`timescale 1ns/100ps
`default_nettype none

module sdramSubsystem
    import sdramPkg::*;
#(
    parameter int casLatency      = 2,
    parameter int initCycles      = 10000,
    parameter int refreshInterval = 780,
    parameter int tRcd            = 2,
    parameter int tRp             = 2,
    parameter int tRfc            = 7
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      chipEnable,
    input  logic                      read,
    input  logic                      write,
    input  logic [3:0]                byteEnable,
    input  logic [HOST_ADDR_BITS-1:0] address,
    input  logic [31:0]               dataIn,
    output logic                      waitRequest,
    output logic                      readValid,
    output logic [31:0]               dataOut,
    output logic [ROW_BITS-1:0]       sdramAddr,
    output logic [BANK_BITS-1:0]      sdramBa,
    output logic                      sdramCasN,
    output logic                      sdramCke,
    output logic                      sdramCsN,
    output logic                      sdramRasN,
    output logic                      sdramWeN,
    output logic [1:0]                sdramDqm,
    output logic [15:0]               dqOut,
    output logic                      dqOutEnable,
    input  logic [15:0]               dqIn
);

    sdramHostIf hostBus ();
    sdramCmdIf  cmdBus ();

    sdramWidthAdapter u_widthAdapter (
        .clk, .reset, .chipEnable, .read, .write, .byteEnable, .address, .dataIn,
        .waitRequest, .readValid, .dataOut,
        .host (hostBus.adapter)
    );

    sdramController #(
        .initCycles (initCycles), .refreshInterval (refreshInterval),
        .tRcd (tRcd), .tRp (tRp), .tRfc (tRfc)
    ) u_controller (
        .clk, .reset,
        .host   (hostBus.controller),
        .cmdOut (cmdBus.controller),
        .cke    (sdramCke)
    );

    sdramPhy #(.casLatency (casLatency)) u_phy (
        .clk, .reset,
        .cmdIn (cmdBus.phy),
        .sdramAddr, .sdramBa, .sdramDqm, .sdramCasN, .sdramRasN, .sdramWeN, .sdramCsN,
        .dqOut, .dqOutEnable, .dqIn
    );

endmodule

`default_nettype wire

// File: hdl/sdramWidthAdapter.sv
`timescale 1ns/100ps
`default_nettype none

module sdramWidthAdapter
    import sdramPkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      chipEnable,
    input  logic                      read,
    input  logic                      write,
    input  logic [3:0]                byteEnable,
    input  logic [HOST_ADDR_BITS-1:0] address,
    input  logic [31:0]               dataIn,
    output logic                      waitRequest,
    output logic                      readValid,
    output logic [31:0]               dataOut,
    sdramHostIf.adapter               host
);

    logic        active;
    logic        wordCount;    // 0 = upper half, 1 = lower half
    logic        readCount;
    logic [1:0]  byteEnMux;
    logic [15:0] dataInMux;
    logic [15:0] upperReg;

    assign active = chipEnable && (read || write);

    // host only sees the accept of the second half
    assign waitRequest = !wordCount || host.waitRequest;
    assign readValid   = readCount && host.rdValid;
    assign dataOut     = {upperReg, host.rdData};

    assign host.rd          = chipEnable && read;
    assign host.wr          = chipEnable && write;
    assign host.addr        = {address, wordCount};   // upper half at the even address
    assign host.byteEnableN = byteEnMux;
    assign host.wrData      = dataInMux;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wordCount <= 1'b0;
        end else if (active && !host.waitRequest) begin
            wordCount <= !wordCount;   // half accepted by the controller
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readCount <= 1'b0;
        end else if (host.rdValid) begin
            readCount <= !readCount;
        end
    end

    // first returned word is the upper half
    always_ff @(posedge clk) begin
        if (!readCount && host.rdValid) begin
            upperReg <= host.rdData;
        end
    end

    always_comb begin
        if (wordCount) begin
            byteEnMux = ~byteEnable[1:0];
            dataInMux = dataIn[15:0];
        end else begin
            byteEnMux = ~byteEnable[3:2];
            dataInMux = dataIn[31:16];
        end
    end

    rdWrExclusive: assert property (@(posedge clk) disable iff (reset)
        chipEnable |-> !(read && write))
        else $error("host read and write high together");

    // a stalled request must not move under the adapter
    requestHeld: assert property (@(posedge clk) disable iff (reset)
        active && waitRequest |=> $stable({read, write, address, dataIn, byteEnable}))
        else $error("host request changed while waitRequest was high");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tbSdramSubsystem -f sdramSubsystem.f \
    -o simTb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simTb > sim.log 2>&1
cat sim.log
grep -qx "STATUS: PASS" sim.log && exit 0 || exit 1

// File: sdramSubsystem.f
hdl/sdramPkg.sv
hdl/sdramHostIf.sv
hdl/sdramCmdIf.sv
hdl/sdramWidthAdapter.sv
hdl/sdramController.sv
hdl/sdramPhy.sv
hdl/sdramSubsystem.sv
sim/sdramModel.sv
sim/tbSdramSubsystem.sv

// File: sim/sdramModel.sv
`timescale 1ns/100ps
`default_nettype none

module sdramModel
    import sdramPkg::*;
(
    input  logic                 clk,
    input  logic [ROW_BITS-1:0]  sdramAddr,
    input  logic [BANK_BITS-1:0] sdramBa,
    input  logic                 sdramCasN,
    input  logic                 sdramCke,
    input  logic                 sdramCsN,
    input  logic                 sdramRasN,
    input  logic                 sdramWeN,
    input  logic [1:0]           sdramDqm,
    input  logic [15:0]          dqOut,
    input  logic                 dqOutEnable,
    output logic [15:0]          dqIn
);

    localparam int CELL_BITS = BANK_BITS + ROW_BITS + COL_BITS;
    localparam int MAX_CL    = 4;

    logic [15:0]              mem [logic [CELL_BITS-1:0]];   // sparse storage
    logic [ROW_BITS-1:0]      openRow [0:(1 << BANK_BITS) - 1];
    logic [MAX_CL-1:0][15:0]  rdPipe;
    logic [1:0]               clIndex = 2'd1;   // CAS latency minus one
    sdramCmd_t                cmdLog [$];       // first commands other than NOP
    int                       refreshCount = 0; // refreshes after LOADMODE
    logic                     modeSet = 1'b0;
    sdramCmd_t                pinCmd;
    logic [CELL_BITS-1:0]     cellAddr;

    assign pinCmd   = sdramCmd_t'({sdramCsN, sdramRasN, sdramCasN, sdramWeN});
    assign cellAddr = {sdramBa, openRow[sdramBa], sdramAddr[COL_BITS-1:0]};
    assign dqIn     = rdPipe[clIndex];

    // unwritten cells return a pattern of their full address
    function automatic logic [15:0] readCell(input logic [CELL_BITS-1:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr[15:0] ^ {7'h00, addr[CELL_BITS-1:16]};
    endfunction

    always @(posedge clk) begin
        logic [15:0] oldWord;
        rdPipe <= {rdPipe[MAX_CL-2:0], (pinCmd == CMD_READ) ? readCell(cellAddr) : 16'h0000};
        if (sdramCke && !sdramCsN && pinCmd != CMD_NOP) begin
            if (cmdLog.size() < 4) begin
                cmdLog.push_back(pinCmd);
            end
            case (pinCmd)
                CMD_ACTIVE: openRow[sdramBa] = sdramAddr;
                CMD_WRITE: if (dqOutEnable) begin
                    oldWord = readCell(cellAddr);
                    mem[cellAddr] = {sdramDqm[1] ? oldWord[15:8] : dqOut[15:8],
                                     sdramDqm[0] ? oldWord[7:0]  : dqOut[7:0]};
                end
                CMD_REFRESH: if (modeSet) begin
                    refreshCount = refreshCount + 1;
                end
                CMD_LOADMODE: begin
                    modeSet = 1'b1;
                    clIndex = 2'(sdramAddr[6:4] - 3'd1);   // latency field of the mode word
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: sim/tbSdramSubsystem.sv
`timescale 1ns/100ps
`default_nettype none

module tbSdramSubsystem
    import sdramPkg::*;
();

    localparam int TIMEOUT = 2000;

    typedef struct packed {
        logic                      isWrite;
        logic [HOST_ADDR_BITS-1:0] addr;
        logic [3:0]                byteEnable;
        logic [31:0]               data;
        logic [31:0]               expected;
    } stimRow_t;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      chipEnable;
    logic                      read;
    logic                      write;
    logic [3:0]                byteEnable;
    logic [HOST_ADDR_BITS-1:0] address;
    logic [31:0]               dataIn;
    logic                      waitRequest;
    logic                      readValid;
    logic [31:0]               dataOut;
    logic [ROW_BITS-1:0]       sdramAddr;
    logic [BANK_BITS-1:0]      sdramBa;
    logic                      sdramCasN;
    logic                      sdramCke;
    logic                      sdramCsN;
    logic                      sdramRasN;
    logic                      sdramWeN;
    logic [1:0]                sdramDqm;
    logic [15:0]               dqOut;
    logic                      dqOutEnable;
    logic [15:0]               dqIn;

    stimRow_t                  stimTab [$];
    logic [31:0]               shadow [logic [HOST_ADDR_BITS-1:0]];   // host view of memory
    logic [HOST_ADDR_BITS-1:0] randAddrs [$];
    sdramCmd_t                 initOrder [$] = '{CMD_PRECHARGE, CMD_REFRESH, CMD_REFRESH,
                                                 CMD_LOADMODE};
    integer                    seed = 66;

    always #10 clk = ~clk;

    sdramSubsystem #(.initCycles (40), .refreshInterval (200)) u_sdramSubsystem (.*);

    sdramModel u_model (.*);

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped after the first error");
    endtask

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            stopOnError($sformatf("** Error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkCmd(input string name, input sdramCmd_t expected,
                            input sdramCmd_t actual);
        if (actual !== expected) begin
            stopOnError($sformatf("** Error: %s expected %s actual %s", name,
                                  expected.name(), actual.name()));
        end
    endtask

    // expected values follow byte-wise merging into the shadow copy
    function automatic void addRow(input logic isWrite, input logic [HOST_ADDR_BITS-1:0] addr,
                                   input logic [3:0] be, input logic [31:0] data);
        stimRow_t    row;
        logic [31:0] mask;
        logic [31:0] oldWord;
        mask    = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        oldWord = shadow.exists(addr) ? shadow[addr] : 32'h0;
        row     = '{isWrite, addr, be, data, oldWord};
        if (isWrite) begin
            row.expected = (oldWord & ~mask) | (data & mask);
            shadow[addr] = row.expected;
        end
        stimTab.push_back(row);
    endfunction

    // one 32-bit host access starting and ending 2 ns after a rising edge
    task automatic hostAccess(input stimRow_t row, output logic [31:0] result);
        int waitCycles;
        waitCycles = 0;
        result     = 32'h0;
        chipEnable = 1'b1;
        read       = !row.isWrite;
        write      = row.isWrite;
        address    = row.addr;
        byteEnable = row.byteEnable;
        dataIn     = row.data;
        @(negedge clk);
        while (waitRequest) begin
            waitCycles++;
            if (waitCycles > TIMEOUT) begin
                stopOnError("timed out waiting for waitRequest to fall");
            end
            @(negedge clk);
        end
        if (u_model.cmdLog.size() < 4) begin
            stopOnError("waitRequest fell before the init sequence had finished");
        end
        @(posedge clk);
        #2;
        chipEnable = 1'b0;
        read       = 1'b0;
        write      = 1'b0;
        if (!row.isWrite) begin
            waitCycles = 0;
            @(negedge clk);
            while (!readValid) begin
                waitCycles++;
                if (waitCycles > TIMEOUT) begin
                    stopOnError("timed out waiting for readValid");
                end
                @(negedge clk);
            end
            result = dataOut;
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        logic [31:0] randWord;
        logic [31:0] result;
        reset      = 1'b1;
        chipEnable = 1'b0;
        read       = 1'b0;
        write      = 1'b0;
        byteEnable = 4'h0;
        address    = '0;
        dataIn     = 32'h0;

        addRow(1'b1, 24'h000010, 4'hF, 32'h1234ABCD);    // full-word round trip
        addRow(1'b0, 24'h000010, 4'hF, 32'h0);
        addRow(1'b1, 24'h1A2B3C, 4'hF, 32'h11223344);
        addRow(1'b1, 24'h1A2B3C, 4'b0101, 32'hAABBCCDD); // bytes 2 and 0 only
        addRow(1'b0, 24'h1A2B3C, 4'hF, 32'h0);
        for (int i = 0; i < 12; i++) begin
            randWord = $random(seed);
            randAddrs.push_back({i[1:0], randWord[21:0]});   // walk all four banks
            randWord = $random(seed);
            addRow(1'b1, randAddrs[i], 4'hF, randWord);
        end
        // repeated readback spans several refresh intervals
        for (int pass = 0; pass < 3; pass++) begin
            foreach (randAddrs[k]) begin
                addRow(1'b0, randAddrs[k], 4'hF, 32'h0);
            end
        end

        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;

        // idle state right after reset, before any request
        @(negedge clk);
        if (waitRequest !== 1'b1 || readValid !== 1'b0) begin
            stopOnError("host waitRequest not high or readValid not low after reset");
        end
        if (sdramCke !== 1'b0 || dqOutEnable !== 1'b0) begin
            stopOnError("SDRAM clock enable or DQ output enable high after reset");
        end
        checkCmd("pin command after reset", CMD_NOP,
                 sdramCmd_t'({sdramCsN, sdramRasN, sdramCasN, sdramWeN}));
        @(posedge clk);
        #2;

        foreach (stimTab[i]) begin
            hostAccess(stimTab[i], result);
            if (!stimTab[i].isWrite) begin
                checkWord($sformatf("row %0d read at %h", i, stimTab[i].addr),
                          stimTab[i].expected, result);
            end
            if (i == 0) begin
                foreach (initOrder[k]) begin
                    checkCmd($sformatf("init command %0d", k), initOrder[k], u_model.cmdLog[k]);
                end
            end
        end

        // upper half at the even 16-bit address
        foreach (shadow[a]) begin
            checkWord($sformatf("model cells of host word %h", a), shadow[a],
                      {u_model.readCell({a, 1'b0}), u_model.readCell({a, 1'b1})});
        end
        if (u_model.refreshCount < 1) begin
            stopOnError("no auto-refresh reached the SDRAM after init");
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
